// ==== sdio_data_pkg.sv ====
// Shared widths, target numbering and state encodings for the SDIO data control block
package sdio_data_pkg;

  // One data byte
  typedef logic [7:0] byte_t;

  // Byte count or block count
  typedef logic [12:0] xfer_cnt_t;

  // Register address within a function
  typedef logic [17:0] sdio_addr_t;

  // Function number taken from the command
  typedef logic [3:0] func_sel_t;

  // CIA, function 1, function 2 and memory
  localparam int N_TARGETS = 4;

  typedef logic [1:0] target_idx_t;
  typedef logic [N_TARGETS-1:0] target_vec_t;

  localparam target_idx_t MEM_TARGET = 2'd3;

  // Byte mode treats a zero count as a full 512 byte transfer
  localparam xfer_cnt_t DEFAULT_BYTE_CNT = 13'd512;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_CONFIG,
    SEQ_ACTIVATE,
    SEQ_WAIT_FOR_PHY,
    SEQ_FINISHED
  } seq_state_t;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WRITE,
    PORT_READ,
    PORT_DONE
  } port_state_t;

endpackage

// ==== seq_link_if.sv ====
// Link between the transfer sequencer and the function router
`timescale 1ns/1ps

interface seq_link_if;

  // Router side: one strobe per byte moved, block size of the selected target
  logic                      byte_stb;
  sdio_data_pkg::xfer_cnt_t  block_size;

  // Sequencer side: host ready level and PHY activate
  logic                      data_rdy;
  logic                      phy_activate;

  modport sequencer (
    input  byte_stb,
    input  block_size,
    output data_rdy,
    output phy_activate
  );

  modport router (
    output byte_stb,
    output block_size,
    input  data_rdy,
    input  phy_activate
  );

endinterface

// ==== transfer_sequencer.sv ====
// Byte and block mode transfer sequencer with byte, block and address counters
`timescale 1ns/1ps

module transfer_sequencer (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        i_activate,
  input  logic                        i_block_mode_flg,
  input  logic                        i_inc_addr_flg,
  input  sdio_data_pkg::xfer_cnt_t    i_data_cnt,
  input  sdio_data_pkg::sdio_addr_t   i_cmd_address,
  input  logic                        i_data_phy_finished,

  seq_link_if.sequencer               link,

  output sdio_data_pkg::xfer_cnt_t    o_total_data_cnt,
  output sdio_data_pkg::sdio_addr_t   o_address,
  output logic                        o_finished
);

  sdio_data_pkg::seq_state_t  state;
  sdio_data_pkg::xfer_cnt_t   byte_cnt;
  sdio_data_pkg::xfer_cnt_t   block_cnt;
  sdio_data_pkg::xfer_cnt_t   total_block_cnt;
  // Block mode with zero count, runs until activate drops
  logic                       continuous;
  sdio_data_pkg::xfer_cnt_t   block_byte_cnt;

  // Bytes in the next block or in the single byte mode transfer
  always_comb begin
    if (i_block_mode_flg) begin
      block_byte_cnt = link.block_size;
    end else if (i_data_cnt == '0) begin
      block_byte_cnt = sdio_data_pkg::DEFAULT_BYTE_CNT;
    end else begin
      block_byte_cnt = i_data_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= sdio_data_pkg::SEQ_IDLE;
      byte_cnt          <= '0;
      block_cnt         <= '0;
      total_block_cnt   <= '0;
      continuous        <= 1'b0;
      o_total_data_cnt  <= '0;
      o_address         <= '0;
      o_finished        <= 1'b0;
      link.data_rdy     <= 1'b0;
      link.phy_activate <= 1'b0;
    end else begin
      case (state)
        sdio_data_pkg::SEQ_IDLE: begin
          byte_cnt          <= '0;
          block_cnt         <= '0;
          o_total_data_cnt  <= '0;
          o_finished        <= 1'b0;
          link.data_rdy     <= 1'b0;
          link.phy_activate <= 1'b0;
          o_address         <= i_cmd_address;
          continuous        <= i_block_mode_flg && (i_data_cnt == '0);
          total_block_cnt   <= i_block_mode_flg ? i_data_cnt : '0;
          if (i_activate) begin
            state <= sdio_data_pkg::SEQ_CONFIG;
          end
        end

        // One cycle to latch the size of the coming block
        sdio_data_pkg::SEQ_CONFIG: begin
          byte_cnt          <= '0;
          o_total_data_cnt  <= block_byte_cnt;
          link.data_rdy     <= 1'b1;
          link.phy_activate <= 1'b1;
          if (i_block_mode_flg && !continuous) begin
            block_cnt <= block_cnt + 1'b1;
          end
          state <= sdio_data_pkg::SEQ_ACTIVATE;
        end

        sdio_data_pkg::SEQ_ACTIVATE: begin
          if (byte_cnt < o_total_data_cnt) begin
            if (link.byte_stb) begin
              byte_cnt <= byte_cnt + 1'b1;
              if (i_inc_addr_flg) begin
                o_address <= o_address + 1'b1;
              end
            end
          end else begin
            link.data_rdy <= 1'b0;
            if (i_block_mode_flg) begin
              state <= sdio_data_pkg::SEQ_WAIT_FOR_PHY;
            end else begin
              state <= sdio_data_pkg::SEQ_FINISHED;
            end
          end
        end

        // PHY still sends the CRC and busy phase of the block
        sdio_data_pkg::SEQ_WAIT_FOR_PHY: begin
          if (i_data_phy_finished) begin
            link.phy_activate <= 1'b0;
            if (continuous || (block_cnt < total_block_cnt)) begin
              state <= sdio_data_pkg::SEQ_CONFIG;
            end else begin
              state <= sdio_data_pkg::SEQ_FINISHED;
            end
          end
        end

        sdio_data_pkg::SEQ_FINISHED: begin
          link.phy_activate <= 1'b0;
          o_finished        <= 1'b1;
        end

        default: begin
          state <= sdio_data_pkg::SEQ_FINISHED;
        end
      endcase

      // Dropping activate cancels the transfer from any state
      if (!i_activate) begin
        state             <= sdio_data_pkg::SEQ_IDLE;
        link.data_rdy     <= 1'b0;
        link.phy_activate <= 1'b0;
      end
    end
  end

  a_rdy_in_activate: assert property (@(posedge clk) disable iff (rst)
    link.data_rdy |-> (state == sdio_data_pkg::SEQ_ACTIVATE));

  a_cnt_in_range: assert property (@(posedge clk) disable iff (rst)
    byte_cnt <= o_total_data_cnt);

endmodule

// ==== cmd_byte_port.sv ====
// Single byte reader and writer for transfers owned by the command bus
`timescale 1ns/1ps

module cmd_byte_port (
  input  logic  clk,
  input  logic  rst,

  input  logic  i_cmd_bus_sel,
  input  logic  i_activate,
  input  logic  i_write_flg,
  input  logic  i_com_rdy,
  input  logic  i_tgt_rd_stb,

  output logic  o_cmd_wr_stb
);

  sdio_data_pkg::port_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= sdio_data_pkg::PORT_IDLE;
      o_cmd_wr_stb <= 1'b0;
    end else begin
      o_cmd_wr_stb <= 1'b0;
      case (state)
        sdio_data_pkg::PORT_IDLE: begin
          if (i_cmd_bus_sel && i_activate) begin
            if (i_write_flg) begin
              state <= sdio_data_pkg::PORT_WRITE;
            end else begin
              state <= sdio_data_pkg::PORT_READ;
            end
          end
        end

        // Target and sequencer both ready, push the byte
        sdio_data_pkg::PORT_WRITE: begin
          if (i_com_rdy) begin
            o_cmd_wr_stb <= 1'b1;
            state        <= sdio_data_pkg::PORT_DONE;
          end
        end

        // Target presents the byte with its read strobe
        sdio_data_pkg::PORT_READ: begin
          if (i_tgt_rd_stb) begin
            state <= sdio_data_pkg::PORT_DONE;
          end
        end

        sdio_data_pkg::PORT_DONE: begin
          if (!i_activate) begin
            state <= sdio_data_pkg::PORT_IDLE;
          end
        end

        default: begin
          state <= sdio_data_pkg::PORT_DONE;
        end
      endcase

      // Abort while still waiting
      if (!i_activate) begin
        state <= sdio_data_pkg::PORT_IDLE;
      end
    end
  end

  a_single_wr_stb: assert property (@(posedge clk) disable iff (rst)
    o_cmd_wr_stb |=> !o_cmd_wr_stb);

endmodule

// ==== function_router.sv ====
// Target decode and data muxes between the command bus, the data PHY and the targets
`timescale 1ns/1ps

module function_router (
  input  logic                                                    clk,
  input  logic                                                    rst,

  // Command side
  input  logic                                                    i_cmd_bus_sel,
  input  logic                                                    i_mem_sel,
  input  sdio_data_pkg::func_sel_t                                i_func_sel,
  input  logic                                                    i_activate,
  input  logic                                                    i_cmd_wr_stb,
  input  sdio_data_pkg::byte_t                                    i_cmd_wr_data,

  // Data PHY
  input  logic                                                    i_phy_wr_stb,
  input  sdio_data_pkg::byte_t                                    i_phy_wr_data,

  // Targets
  input  sdio_data_pkg::target_vec_t                              i_tgt_rd_stb,
  input  sdio_data_pkg::byte_t     [sdio_data_pkg::N_TARGETS-1:0] i_tgt_rd_data,
  input  sdio_data_pkg::target_vec_t                              i_tgt_com_rdy,
  input  sdio_data_pkg::xfer_cnt_t [sdio_data_pkg::N_TARGETS-1:0] i_tgt_block_size,

  seq_link_if.router                                              link,

  output logic                                                    o_sel_rd_stb,
  output logic                                                    o_com_rdy,

  output sdio_data_pkg::byte_t                                    o_cmd_rd_data,

  output logic                                                    o_phy_rd_stb,
  output sdio_data_pkg::byte_t                                    o_phy_rd_data,
  output logic                                                    o_phy_com_rdy,
  output logic                                                    o_phy_activate,

  output sdio_data_pkg::target_vec_t                              o_tgt_wr_stb,
  output sdio_data_pkg::byte_t     [sdio_data_pkg::N_TARGETS-1:0] o_tgt_wr_data,
  output sdio_data_pkg::target_vec_t                              o_tgt_hst_rdy,
  output sdio_data_pkg::target_vec_t                              o_tgt_activate
);

  sdio_data_pkg::target_idx_t tgt_idx;
  logic                       tgt_valid;
  logic                       wr_stb;
  sdio_data_pkg::byte_t       wr_data;
  logic                       sel_rd_stb;
  sdio_data_pkg::byte_t       sel_rd_data;
  logic                       sel_com_rdy;

  // Memory wins over the function number, functions 3 to 15 have no target
  always_comb begin
    tgt_valid = 1'b0;
    tgt_idx   = '0;
    if (i_mem_sel) begin
      tgt_valid = 1'b1;
      tgt_idx   = sdio_data_pkg::MEM_TARGET;
    end else if (i_func_sel < 4'd3) begin
      tgt_valid = 1'b1;
      tgt_idx   = i_func_sel[1:0];
    end
  end

  // Write source
  assign wr_stb  = i_cmd_bus_sel ? i_cmd_wr_stb  : i_phy_wr_stb;
  assign wr_data = i_cmd_bus_sel ? i_cmd_wr_data : i_phy_wr_data;

  // Toward the targets, only the selected one sees traffic
  always_comb begin
    o_tgt_wr_stb   = '0;
    o_tgt_wr_data  = '0;
    o_tgt_hst_rdy  = '0;
    o_tgt_activate = '0;
    if (tgt_valid) begin
      o_tgt_wr_stb[tgt_idx]   = wr_stb;
      o_tgt_wr_data[tgt_idx]  = wr_data;
      o_tgt_hst_rdy[tgt_idx]  = link.data_rdy;
      o_tgt_activate[tgt_idx] = i_activate;
    end
  end

  // Back from the selected target
  assign sel_rd_stb  = tgt_valid & i_tgt_rd_stb[tgt_idx];
  assign sel_rd_data = tgt_valid ? i_tgt_rd_data[tgt_idx] : '0;
  assign sel_com_rdy = tgt_valid & i_tgt_com_rdy[tgt_idx] & link.data_rdy;

  assign link.byte_stb   = (tgt_valid & wr_stb) | sel_rd_stb;
  assign link.block_size = tgt_valid ? i_tgt_block_size[tgt_idx] : '0;

  assign o_sel_rd_stb = sel_rd_stb;
  assign o_com_rdy    = sel_com_rdy;

  assign o_cmd_rd_data = i_cmd_bus_sel ? sel_rd_data : '0;

  // PHY side is silent while the command bus owns the path
  assign o_phy_rd_stb   = !i_cmd_bus_sel & sel_rd_stb;
  assign o_phy_rd_data  = i_cmd_bus_sel ? '0 : sel_rd_data;
  assign o_phy_com_rdy  = !i_cmd_bus_sel & sel_com_rdy;
  assign o_phy_activate = !i_cmd_bus_sel & link.phy_activate;

  a_one_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0(o_tgt_activate));

endmodule

// ==== sdio_data_control.sv ====
// SDIO data control top level joining sequencer, command byte port and function router
`timescale 1ns/1ps

module sdio_data_control (
  input  logic                                                    clk,
  input  logic                                                    rst,

  input  logic                                                    i_write_flg,
  input  logic                                                    i_block_mode_flg,
  input  sdio_data_pkg::xfer_cnt_t                                i_data_cnt,
  output sdio_data_pkg::xfer_cnt_t                                o_total_data_cnt,

  input  logic                                                    i_inc_addr_flg,
  input  sdio_data_pkg::sdio_addr_t                               i_cmd_address,
  output sdio_data_pkg::sdio_addr_t                               o_address,

  input  logic                                                    i_activate,
  output logic                                                    o_finished,

  input  logic                                                    i_cmd_bus_sel,
  input  logic                                                    i_mem_sel,
  input  sdio_data_pkg::func_sel_t                                i_func_sel,

  // Command bus
  input  sdio_data_pkg::byte_t                                    i_cmd_wr_data,
  output sdio_data_pkg::byte_t                                    o_cmd_rd_data,

  // Data PHY
  input  logic                                                    i_data_phy_wr_stb,
  input  sdio_data_pkg::byte_t                                    i_data_phy_wr_data,
  output logic                                                    o_data_phy_rd_stb,
  output sdio_data_pkg::byte_t                                    o_data_phy_rd_data,
  output logic                                                    o_data_phy_com_rdy,
  output logic                                                    o_data_phy_activate,
  input  logic                                                    i_data_phy_finished,

  // Targets, indexed CIA, function 1, function 2, memory
  output sdio_data_pkg::target_vec_t                              o_tgt_wr_stb,
  output sdio_data_pkg::byte_t     [sdio_data_pkg::N_TARGETS-1:0] o_tgt_wr_data,
  input  sdio_data_pkg::target_vec_t                              i_tgt_rd_stb,
  input  sdio_data_pkg::byte_t     [sdio_data_pkg::N_TARGETS-1:0] i_tgt_rd_data,
  output sdio_data_pkg::target_vec_t                              o_tgt_hst_rdy,
  input  sdio_data_pkg::target_vec_t                              i_tgt_com_rdy,
  output sdio_data_pkg::target_vec_t                              o_tgt_activate,
  input  sdio_data_pkg::xfer_cnt_t [sdio_data_pkg::N_TARGETS-1:0] i_tgt_block_size
);

  logic tgt_rd_stb;
  logic com_rdy;
  logic cmd_wr_stb;

  seq_link_if link ();

  transfer_sequencer u_seq (
    .clk                 (clk),
    .rst                 (rst),
    .i_activate          (i_activate),
    .i_block_mode_flg    (i_block_mode_flg),
    .i_inc_addr_flg      (i_inc_addr_flg),
    .i_data_cnt          (i_data_cnt),
    .i_cmd_address       (i_cmd_address),
    .i_data_phy_finished (i_data_phy_finished),
    .link                (link.sequencer),
    .o_total_data_cnt    (o_total_data_cnt),
    .o_address           (o_address),
    .o_finished          (o_finished)
  );

  cmd_byte_port u_port (
    .clk           (clk),
    .rst           (rst),
    .i_cmd_bus_sel (i_cmd_bus_sel),
    .i_activate    (i_activate),
    .i_write_flg   (i_write_flg),
    .i_com_rdy     (com_rdy),
    .i_tgt_rd_stb  (tgt_rd_stb),
    .o_cmd_wr_stb  (cmd_wr_stb)
  );

  function_router u_router (
    .clk              (clk),
    .rst              (rst),
    .i_cmd_bus_sel    (i_cmd_bus_sel),
    .i_mem_sel        (i_mem_sel),
    .i_func_sel       (i_func_sel),
    .i_activate       (i_activate),
    .i_cmd_wr_stb     (cmd_wr_stb),
    .i_cmd_wr_data    (i_cmd_wr_data),
    .i_phy_wr_stb     (i_data_phy_wr_stb),
    .i_phy_wr_data    (i_data_phy_wr_data),
    .i_tgt_rd_stb     (i_tgt_rd_stb),
    .i_tgt_rd_data    (i_tgt_rd_data),
    .i_tgt_com_rdy    (i_tgt_com_rdy),
    .i_tgt_block_size (i_tgt_block_size),
    .link             (link.router),
    .o_sel_rd_stb     (tgt_rd_stb),
    .o_com_rdy        (com_rdy),
    .o_cmd_rd_data    (o_cmd_rd_data),
    .o_phy_rd_stb     (o_data_phy_rd_stb),
    .o_phy_rd_data    (o_data_phy_rd_data),
    .o_phy_com_rdy    (o_data_phy_com_rdy),
    .o_phy_activate   (o_data_phy_activate),
    .o_tgt_wr_stb     (o_tgt_wr_stb),
    .o_tgt_wr_data    (o_tgt_wr_data),
    .o_tgt_hst_rdy    (o_tgt_hst_rdy),
    .o_tgt_activate   (o_tgt_activate)
  );

endmodule

// ==== sdio_data_control_tb.sv ====
// Directed testbench for the SDIO data control block with a target model and a watchdog
`timescale 1ns/1ps

module sdio_data_control_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  // Longest wait for any single DUT response
  localparam int WAIT_LIMIT   = 20;

  // Cycle budget of each test
  localparam int ROUTING_CYCLES    = 10;
  localparam int BYTE_MODE_CYCLES  = 3 * WAIT_LIMIT + 15;
  localparam int BLOCK_MODE_CYCLES = 5 * WAIT_LIMIT + 20;
  localparam int CMD_WRITE_CYCLES  = WAIT_LIMIT + 10;
  localparam int CMD_READ_CYCLES   = 3 * WAIT_LIMIT + 20;
  localparam int MARGIN_CYCLES     = 100;
  localparam int WATCHDOG_CYCLES   = RESET_CYCLES + ROUTING_CYCLES + BYTE_MODE_CYCLES +
                                     BLOCK_MODE_CYCLES + CMD_WRITE_CYCLES +
                                     CMD_READ_CYCLES + MARGIN_CYCLES;

  localparam int NT = sdio_data_pkg::N_TARGETS;

  logic                                  clk;
  logic                                  rst;
  logic                                  i_write_flg;
  logic                                  i_block_mode_flg;
  sdio_data_pkg::xfer_cnt_t              i_data_cnt;
  sdio_data_pkg::xfer_cnt_t              o_total_data_cnt;
  logic                                  i_inc_addr_flg;
  sdio_data_pkg::sdio_addr_t             i_cmd_address;
  sdio_data_pkg::sdio_addr_t             o_address;
  logic                                  i_activate;
  logic                                  o_finished;
  logic                                  i_cmd_bus_sel;
  logic                                  i_mem_sel;
  sdio_data_pkg::func_sel_t              i_func_sel;
  sdio_data_pkg::byte_t                  i_cmd_wr_data;
  sdio_data_pkg::byte_t                  o_cmd_rd_data;
  logic                                  i_data_phy_wr_stb;
  sdio_data_pkg::byte_t                  i_data_phy_wr_data;
  logic                                  o_data_phy_rd_stb;
  sdio_data_pkg::byte_t                  o_data_phy_rd_data;
  logic                                  o_data_phy_com_rdy;
  logic                                  o_data_phy_activate;
  logic                                  i_data_phy_finished;
  sdio_data_pkg::target_vec_t            o_tgt_wr_stb;
  sdio_data_pkg::byte_t     [NT-1:0]     o_tgt_wr_data;
  sdio_data_pkg::target_vec_t            i_tgt_rd_stb;
  sdio_data_pkg::byte_t     [NT-1:0]     i_tgt_rd_data;
  sdio_data_pkg::target_vec_t            o_tgt_hst_rdy;
  sdio_data_pkg::target_vec_t            i_tgt_com_rdy;
  sdio_data_pkg::target_vec_t            o_tgt_activate;
  sdio_data_pkg::xfer_cnt_t [NT-1:0]     i_tgt_block_size;

  sdio_data_control DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fixed read data of each target model
  function automatic sdio_data_pkg::byte_t model_rd_data(input int t);
    return 8'ha0 + 8'(t);
  endfunction

  // Block size of each target model, function 1 uses 4
  function automatic sdio_data_pkg::xfer_cnt_t model_block_size(input int t);
    return (t == 1) ? 13'd4 : 13'(8 * (t + 1));
  endfunction

  // Target model, always ready
  initial begin
    i_tgt_com_rdy = '1;
    for (int t = 0; t < NT; t++) begin
      i_tgt_rd_data[t]    = model_rd_data(t);
      i_tgt_block_size[t] = model_block_size(t);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    assert (actual === expected) else begin
      $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("error at %0t ns: %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic wait_phy_com_rdy(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_data_phy_com_rdy !== level && n < WAIT_LIMIT);
    check_true(o_data_phy_com_rdy === level, "PHY com_rdy did not reach the expected level");
  endtask

  task automatic wait_hst_rdy(input int t);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_tgt_hst_rdy[t] !== 1'b1 && n < WAIT_LIMIT);
    check_true(o_tgt_hst_rdy[t], "target host ready never rose");
  endtask

  task automatic wait_finished();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (o_finished !== 1'b1 && n < WAIT_LIMIT);
    check_true(o_finished, "transfer did not finish in time");
  endtask

  // Back to back PHY write strobes with random data
  task automatic send_phy_bytes(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      i_data_phy_wr_stb  = 1'b1;
      i_data_phy_wr_data = 8'($urandom());
      #1;
      check_value(o_data_phy_activate, 1, "PHY activate during a block");
    end
    @(negedge clk);
    i_data_phy_wr_stb = 1'b0;
  endtask

  task automatic end_transfer();
    @(negedge clk);
    i_activate = 1'b0;
    repeat (2) @(negedge clk);
    check_value(o_finished, 0, "finished after activate dropped");
    check_value(o_data_phy_activate, 0, "PHY activate after activate dropped");
  endtask

  task automatic check_reset_state();
    check_value(o_finished, 0, "finished after reset");
    check_value(o_tgt_activate, 0, "target activates after reset");
    check_value(o_tgt_wr_stb, 0, "target write strobes after reset");
    check_value(o_data_phy_activate, 0, "PHY activate after reset");
    check_value(o_data_phy_com_rdy, 0, "PHY com_rdy after reset");
  endtask

  task automatic route_phy_write(input logic mem_sel, input sdio_data_pkg::func_sel_t func_sel,
                                 input sdio_data_pkg::target_vec_t expected);
    sdio_data_pkg::byte_t data;
    sdio_data_pkg::byte_t exp_rd;
    data   = 8'($urandom());
    exp_rd = 8'h00;
    for (int t = 0; t < NT; t++) begin
      if (expected[t]) begin
        exp_rd = model_rd_data(t);
      end
    end
    @(negedge clk);
    i_mem_sel          = mem_sel;
    i_func_sel         = func_sel;
    i_activate         = 1'b1;
    i_data_phy_wr_stb  = 1'b1;
    i_data_phy_wr_data = data;
    i_tgt_rd_stb       = '1;
    #1;
    check_value(o_tgt_wr_stb, expected, "routed write strobes");
    check_value(o_tgt_activate, expected, "routed activates");
    for (int t = 0; t < NT; t++) begin
      check_value(o_tgt_wr_data[t], expected[t] ? data : 8'h00, "routed write data");
    end
    check_value(o_data_phy_rd_stb, |expected, "PHY read strobe from the selected target");
    check_value(o_data_phy_rd_data, exp_rd, "PHY read data from the selected target");
    @(negedge clk);
    i_data_phy_wr_stb = 1'b0;
    i_activate        = 1'b0;
    i_tgt_rd_stb      = '0;
    #1;
    check_value(o_tgt_wr_stb, 0, "write strobes after the strobe ended");
  endtask

  task automatic phy_routing();
    i_cmd_bus_sel = 1'b0;
    route_phy_write(1'b0, 4'd2, 4'b0100);
    route_phy_write(1'b1, 4'd2, 4'b1000);
    route_phy_write(1'b0, 4'd5, 4'b0000);
  endtask

  task automatic byte_mode_transfer();
    sdio_data_pkg::sdio_addr_t start_addr;
    start_addr = 18'($urandom());
    @(negedge clk);
    i_mem_sel        = 1'b0;
    i_func_sel       = 4'd1;
    i_block_mode_flg = 1'b0;
    i_inc_addr_flg   = 1'b1;
    i_data_cnt       = 13'd5;
    i_cmd_address    = start_addr;
    i_activate       = 1'b1;
    wait_phy_com_rdy(1'b1);
    check_value(o_total_data_cnt, 5, "byte mode total count");
    send_phy_bytes(5);
    wait_finished();
    check_value(o_address, 18'(start_addr + 18'd5), "address after byte transfer");
    end_transfer();
    // Zero count means a full 512 byte transfer
    @(negedge clk);
    i_data_cnt = '0;
    i_activate = 1'b1;
    wait_phy_com_rdy(1'b1);
    check_value(o_total_data_cnt, 512, "byte mode total count for a zero count");
    end_transfer();
  endtask

  task automatic block_mode_transfer();
    @(negedge clk);
    i_func_sel       = 4'd1;
    i_block_mode_flg = 1'b1;
    i_data_cnt       = 13'd2;
    i_activate       = 1'b1;
    for (int b = 0; b < 2; b++) begin
      wait_phy_com_rdy(1'b1);
      check_value(o_total_data_cnt, model_block_size(1), "block byte count");
      send_phy_bytes(int'(model_block_size(1)));
      wait_phy_com_rdy(1'b0);
      check_value(o_finished, 0, "finished before the last block ended");
      @(negedge clk);
      i_data_phy_finished = 1'b1;
      @(negedge clk);
      i_data_phy_finished = 1'b0;
    end
    wait_finished();
    end_transfer();
    i_block_mode_flg = 1'b0;
  endtask

  task automatic command_write();
    sdio_data_pkg::byte_t data;
    int strobes;
    int n;
    data    = 8'($urandom());
    strobes = 0;
    n       = 0;
    @(negedge clk);
    i_cmd_bus_sel = 1'b1;
    i_write_flg   = 1'b1;
    i_func_sel    = 4'd2;
    i_data_cnt    = 13'd1;
    i_cmd_wr_data = data;
    i_activate    = 1'b1;
    do begin
      @(negedge clk);
      n++;
      check_value(o_tgt_wr_stb & 4'b1011, 0, "write strobe on an unselected target");
      if (o_tgt_wr_stb[2]) begin
        strobes++;
        check_value(o_tgt_wr_data[2], data, "command write data");
      end
      check_value({o_data_phy_rd_stb, o_data_phy_com_rdy, o_data_phy_activate}, 0,
                  "PHY strobes while the command bus owns the path");
      check_value(o_data_phy_rd_data, 0, "PHY read data while the command bus owns the path");
    end while (o_finished !== 1'b1 && n < WAIT_LIMIT);
    check_true(o_finished, "command write did not finish in time");
    check_value(strobes, 1, "number of command write strobes");
    end_transfer();
  endtask

  task automatic command_read_and_abort();
    @(negedge clk);
    i_cmd_bus_sel = 1'b1;
    i_write_flg   = 1'b0;
    i_func_sel    = 4'd0;
    i_data_cnt    = 13'd1;
    i_activate    = 1'b1;
    wait_hst_rdy(0);
    i_tgt_rd_stb = 4'b0001;
    #1;
    check_value(o_cmd_rd_data, model_rd_data(0), "command read data");
    check_value(o_data_phy_rd_stb, 0, "PHY read strobe during a command read");
    @(negedge clk);
    i_tgt_rd_stb = '0;
    wait_finished();
    end_transfer();
    // Memory transfer dropped after three of eight bytes
    @(negedge clk);
    i_cmd_bus_sel = 1'b0;
    i_mem_sel     = 1'b1;
    i_data_cnt    = 13'd8;
    i_activate    = 1'b1;
    wait_phy_com_rdy(1'b1);
    send_phy_bytes(3);
    check_value(o_tgt_activate, 4'b1000, "memory activate during the transfer");
    i_activate = 1'b0;
    #1;
    check_value(o_tgt_activate, 0, "target activate after the abort");
    repeat (3) begin
      @(negedge clk);
      check_value(o_finished, 0, "finished after the abort");
      check_value(o_data_phy_activate, 0, "PHY activate after the abort");
    end
    i_mem_sel = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hc0c70f87));
    rst                 = 1'b1;
    i_write_flg         = 1'b0;
    i_block_mode_flg    = 1'b0;
    i_data_cnt          = '0;
    i_inc_addr_flg      = 1'b0;
    i_cmd_address       = '0;
    i_activate          = 1'b0;
    i_cmd_bus_sel       = 1'b0;
    i_mem_sel           = 1'b0;
    i_func_sel          = '0;
    i_cmd_wr_data       = '0;
    i_data_phy_wr_stb   = 1'b0;
    i_data_phy_wr_data  = '0;
    i_data_phy_finished = 1'b0;
    i_tgt_rd_stb        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    phy_routing();
    byte_mode_transfer();
    block_mode_transfer();
    command_write();
    command_read_and_abort();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== sdio_data_control.f ====
sdio_data_pkg.sv
seq_link_if.sv
transfer_sequencer.sv
cmd_byte_port.sv
function_router.sv
sdio_data_control.sv
sdio_data_control_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sdio_data_control_tb -f sdio_data_control.f -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb 2>&1 | tee sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
